// ==== hdl/wordGamePkg.sv ====
package wordGamePkg;

    // one ASCII character, zero means no key down
    typedef logic [7:0] letter_t;

    // correct and mistake counters
    typedef logic [2:0] count_t;

    localparam int wordLen  = 5;            // letters per word
    localparam int wordBits = wordLen * 8;  // packed word width

    localparam letter_t noKey      = 8'h00;
    localparam letter_t hiddenChar = 8'h5F; // underscore

    typedef enum logic [3:0] {
        setup = 4'd0,
        ready = 4'd1,
        cmp0  = 4'd2,
        cmp1  = 4'd3,
        cmp2  = 4'd4,
        cmp3  = 4'd5,
        cmp4  = 4'd6,
        score = 4'd7,
        over  = 4'd8
    } gameState_t;

endpackage

// ==== hdl/secretWordReg.sv ====
`timescale 1ns/1ps

module secretWordReg import wordGamePkg::*; (
    input  logic                clk,
    input  logic                nRst,
    input  letter_t             wordLetter,
    input  logic                wordLoad,
    input  logic                inSetup,
    input  logic                clearWord,
    input  logic [wordLen-1:0]  hitMask,
    output logic [wordBits-1:0] secretWord,
    output logic                wordValid,
    output logic [wordBits-1:0] revealedWord
);

    localparam int cntBits = $clog2(wordLen + 1);

    logic [cntBits-1:0] loadCnt;
    logic               loadEn;

    assign loadEn = wordLoad && inSetup;

    // letters enter at the low end, first letter ends up in the top byte
    always_ff @(posedge clk) begin
        if (loadEn) begin
            secretWord <= {secretWord[wordBits-9:0], wordLetter};
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            loadCnt <= '0;
        end else if (clearWord) begin
            loadCnt <= '0;
        end else if (loadEn && loadCnt != cntBits'(wordLen)) begin
            loadCnt <= loadCnt + 1'b1; // saturates at a full word
        end
    end

    assign wordValid = (loadCnt == cntBits'(wordLen));

    // mask bit j shows byte j of the word
    always_comb begin
        for (int j = 0; j < wordLen; j++) begin
            if (hitMask[j]) begin
                revealedWord[8*j +: 8] = secretWord[8*j +: 8];
            end else begin
                revealedWord[8*j +: 8] = hiddenChar;
            end
        end
    end

endmodule

// ==== hdl/guessCapture.sv ====
`timescale 1ns/1ps

module guessCapture import wordGamePkg::*; (
    input  logic    clk,
    input  logic    nRst,
    input  letter_t guess,
    output logic    guessStrobe,
    output letter_t guessLetter
);

    letter_t prevGuess;
    logic    keyDown;

    // rising edge of the key level
    assign keyDown = (guess != noKey) && (prevGuess == noKey);

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            prevGuess   <= noKey;
            guessStrobe <= 1'b0;
        end else begin
            prevGuess   <= guess;
            guessStrobe <= keyDown; // one pulse per press
        end
    end

    always_ff @(posedge clk) begin
        if (keyDown) begin
            guessLetter <= guess;
        end
    end

endmodule

// ==== hdl/gameLogic.sv ====
`timescale 1ns/1ps

module gameLogic import wordGamePkg::*; #(
    parameter int maxMistakes = 6
) (
    input  logic                clk,
    input  logic                nRst,
    input  logic [wordBits-1:0] secretWord,
    input  logic                wordValid,
    input  logic                startGame,
    input  logic                gameEnd,
    input  logic                guessStrobe,
    input  letter_t             guessLetter,
    output letter_t             letter,
    output logic                red,
    output logic                green,
    output logic                mistake,
    output logic                gameRdy,
    output count_t              correct,
    output count_t              incorrect,
    output logic [wordLen-1:0]  indexCorrect,
    output logic                inSetup,
    output logic                clearWord
);

    gameState_t state, nextState;

    count_t     tally;          // hits in the current guess
    logic [2:0] posSel;         // mask bit under compare
    letter_t    secretLetter;
    logic       cmpState;
    logic       posHit;
    count_t     newCorrect;
    count_t     newIncorrect;
    logic       gameWon;
    logic       gameLost;

    always_comb begin
        cmpState = 1'b1;
        case (state)
            cmp0:    posSel = 3'd4; // first letter sits in the top byte
            cmp1:    posSel = 3'd3;
            cmp2:    posSel = 3'd2;
            cmp3:    posSel = 3'd1;
            cmp4:    posSel = 3'd0;
            default: begin
                posSel   = 3'd0;
                cmpState = 1'b0;
            end
        endcase
    end

    assign secretLetter = secretWord[8*posSel +: 8];
    assign posHit       = cmpState && (letter == secretLetter) && !indexCorrect[posSel];

    assign newCorrect   = correct + tally;
    assign newIncorrect = incorrect + 3'd1;
    assign gameWon      = (tally != '0) && (newCorrect == count_t'(wordLen));
    assign gameLost     = (tally == '0) && (newIncorrect == count_t'(maxMistakes));

    assign gameRdy   = (state == ready) || (state == over);
    assign inSetup   = (state == setup);
    assign clearWord = gameEnd && gameRdy;
    assign mistake   = (state == score) && (tally == '0);

    always_comb begin
        nextState = state;
        case (state)
            setup: begin
                if (startGame && wordValid) begin
                    nextState = ready;
                end
            end
            ready: begin
                if (gameEnd) begin
                    nextState = setup;
                end else if (guessStrobe) begin
                    nextState = cmp0;
                end
            end
            cmp0:  nextState = cmp1;
            cmp1:  nextState = cmp2;
            cmp2:  nextState = cmp3;
            cmp3:  nextState = cmp4;
            cmp4:  nextState = score;
            score: nextState = (gameWon || gameLost) ? over : ready;
            over: begin
                if (gameEnd) begin
                    nextState = setup;
                end
            end
            default: nextState = setup;
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state        <= setup;
            letter       <= noKey;
            tally        <= '0;
            correct      <= '0;
            incorrect    <= '0;
            indexCorrect <= '0;
            red          <= 1'b0;
            green        <= 1'b0;
        end else begin
            state <= nextState;
            if (clearWord) begin // back to setup
                letter       <= noKey;
                tally        <= '0;
                correct      <= '0;
                incorrect    <= '0;
                indexCorrect <= '0;
                red          <= 1'b0;
                green        <= 1'b0;
            end else if (state == ready && guessStrobe) begin
                letter <= guessLetter;
                tally  <= '0;
            end else if (posHit) begin
                indexCorrect[posSel] <= 1'b1;
                tally                <= tally + 3'd1;
            end else if (state == score) begin
                if (tally == '0) begin
                    incorrect <= newIncorrect;
                    red       <= gameLost;
                end else begin
                    correct <= newCorrect;
                    green   <= gameWon;
                end
            end
        end
    end

endmodule

// ==== hdl/wordGameTop.sv ====
`timescale 1ns/1ps

module wordGameTop import wordGamePkg::*; #(
    parameter int maxMistakes = 6
) (
    input  logic                clk,
    input  logic                nRst,
    input  letter_t             wordLetter,
    input  logic                wordLoad,
    input  logic                startGame,
    input  logic                gameEnd,
    input  letter_t             guess,
    output letter_t             letter,
    output logic                red,
    output logic                green,
    output logic                mistake,
    output logic                gameRdy,
    output count_t              correct,
    output count_t              incorrect,
    output logic [wordLen-1:0]  indexCorrect,
    output logic [wordBits-1:0] revealedWord
);

    logic [wordBits-1:0] secretWord;
    logic                wordValid;
    logic                inSetup;
    logic                clearWord;
    logic                guessStrobe;
    letter_t             guessLetter;

    secretWordReg wordReg (
        .clk          (clk),
        .nRst         (nRst),
        .wordLetter   (wordLetter),
        .wordLoad     (wordLoad),
        .inSetup      (inSetup),
        .clearWord    (clearWord),
        .hitMask      (indexCorrect),
        .secretWord   (secretWord),
        .wordValid    (wordValid),
        .revealedWord (revealedWord)
    );

    guessCapture capture (
        .clk         (clk),
        .nRst        (nRst),
        .guess       (guess),
        .guessStrobe (guessStrobe),
        .guessLetter (guessLetter)
    );

    gameLogic #(
        .maxMistakes (maxMistakes)
    ) logicCore (
        .clk          (clk),
        .nRst         (nRst),
        .secretWord   (secretWord),
        .wordValid    (wordValid),
        .startGame    (startGame),
        .gameEnd      (gameEnd),
        .guessStrobe  (guessStrobe),
        .guessLetter  (guessLetter),
        .letter       (letter),
        .red          (red),
        .green        (green),
        .mistake      (mistake),
        .gameRdy      (gameRdy),
        .correct      (correct),
        .incorrect    (incorrect),
        .indexCorrect (indexCorrect), // also the reveal mask
        .inSetup      (inSetup),
        .clearWord    (clearWord)
    );

endmodule

// ==== sim/wordGameTb.sv ====
`timescale 1ns/1ps

module wordGameTb import wordGamePkg::*; ();

    localparam string casesFile    = "sim/wordGameCases.txt";
    localparam int    guessLimit   = 40;
    localparam int    settleCycles = 8;    // key press to updated counts

    logic                clk;
    logic                nRst;
    letter_t             wordLetter;
    logic                wordLoad;
    logic                startGame;
    logic                gameEnd;
    letter_t             guess;
    letter_t             letter;
    logic                red;
    logic                green;
    logic                mistake;
    logic                gameRdy;
    count_t              correct;
    count_t              incorrect;
    logic [wordLen-1:0]  indexCorrect;
    logic [wordBits-1:0] revealedWord;

    int                  errors;
    int                  checks;
    int                  caseCount;
    logic [31:0]         rngState;
    logic [wordBits-1:0] refWord;     // secret word as given in the cases file

    wordGameTop #(
        .maxMistakes (6)
    ) dut (
        .clk          (clk),
        .nRst         (nRst),
        .wordLetter   (wordLetter),
        .wordLoad     (wordLoad),
        .startGame    (startGame),
        .gameEnd      (gameEnd),
        .guess        (guess),
        .letter       (letter),
        .red          (red),
        .green        (green),
        .mistake      (mistake),
        .gameRdy      (gameRdy),
        .correct      (correct),
        .incorrect    (incorrect),
        .indexCorrect (indexCorrect),
        .revealedWord (revealedWord)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // mask bit j uncovers byte j with the first letter in the top byte
    function automatic logic [wordBits-1:0] expectReveal(input logic [wordBits-1:0] word,
                                                         input logic [wordLen-1:0]  mask);
        logic [wordBits-1:0] shown;
        for (int j = 0; j < wordLen; j++) begin
            shown[8*j +: 8] = mask[j] ? word[8*j +: 8] : hiddenChar;
        end
        return shown;
    endfunction

    task automatic checkCount(input string name, input count_t got, input count_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkLetter(input string name, input letter_t got, input letter_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkMask(input string name, input logic [wordLen-1:0] got,
                             input logic [wordLen-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkWord(input string name, input logic [wordBits-1:0] got,
                             input logic [wordBits-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkIdle();
        checkFlag("gameRdy", gameRdy, 1'b0);
        checkFlag("red", red, 1'b0);
        checkFlag("green", green, 1'b0);
        checkCount("correct", correct, '0);
        checkCount("incorrect", incorrect, '0);
        checkMask("indexCorrect", indexCorrect, '0);
        checkLetter("letter", letter, noKey);
        checkWord("revealedWord", revealedWord, {wordLen{hiddenChar}});
    endtask

    // one key press, held on into the idle cycles after the guess
    task automatic playGuess(input letter_t key, output int pulses);
        int   hold;
        int   n;
        logic busySeen;
        logic done;
        logic rearmed;
        rngState = xorshift32(rngState);
        hold     = int'(rngState % 32'd6) + 1;
        pulses   = 0;
        n        = 0;
        busySeen = 1'b0;
        done     = 1'b0;
        rearmed  = 1'b0;
        guess    = key;
        while (!done && n < guessLimit) begin
            @(negedge clk);
            n++;
            if (mistake) begin
                pulses++;
            end
            if (!gameRdy) begin
                busySeen = 1'b1;
            end
            done = gameRdy && (busySeen || n >= settleCycles);
        end
        if (!done) begin
            errors++;
            $display("gameRdy did not return within %0d cycles after guess 0x%h", guessLimit, key);
        end
        // a key still down must not start a second guess
        for (int k = 0; k < hold + settleCycles; k++) begin
            if (k == hold) begin
                guess = noKey;
            end
            @(negedge clk);
            if (mistake) begin
                pulses++;
            end
            if (!gameRdy) begin
                rearmed = 1'b1;
            end
        end
        if (done && rearmed) begin
            errors++;
            $display("held key 0x%h started another guess", key);
        end
        if (pulses > 1) begin
            errors++;
            $display("mistake pulsed %0d times for one key press 0x%h", pulses, key);
        end
    endtask

    task automatic countCases();
        int    fd;
        string line;
        caseCount = 0;
        fd = $fopen(casesFile, "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    caseCount++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic runCases();
        int          fd;
        int          pulses;
        string       line;
        logic [7:0]  cmd;
        logic [39:0] arg;
        logic [7:0]  eCorrect;
        logic [7:0]  eIncorrect;
        logic [7:0]  eMask;
        logic [7:0]  eMistake;
        logic [7:0]  eRed;
        logic [7:0]  eGreen;
        letter_t     expLetter;
        logic        overSeen;     // a lamp is lit, guesses are dropped
        expLetter = noKey;
        overSeen  = 1'b0;
        fd = $fopen(casesFile, "r");
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin
                void'($sscanf(line, "%c %h %h %h %h %h %h %h", cmd, arg, eCorrect,
                              eIncorrect, eMask, eMistake, eRed, eGreen));
                case (cmd)
                    "w": refWord = arg;
                    "l": begin
                        wordLetter = letter_t'(arg);
                        wordLoad   = 1'b1;
                        @(negedge clk);
                        wordLoad   = 1'b0;
                    end
                    "s": begin
                        startGame = 1'b1;
                        @(negedge clk);
                        startGame = 1'b0;
                        checkFlag("gameRdy", gameRdy, arg[0]);
                    end
                    "e": begin
                        gameEnd = 1'b1;
                        @(negedge clk);
                        gameEnd = 1'b0;
                        expLetter = noKey;
                        overSeen  = 1'b0;
                        checkIdle();
                    end
                    "g": begin
                        playGuess(letter_t'(arg), pulses);
                        if (!overSeen) begin
                            expLetter = letter_t'(arg);
                        end
                        checkLetter("letter", letter, expLetter);
                        checkCount("correct", correct, count_t'(eCorrect));
                        checkCount("incorrect", incorrect, count_t'(eIncorrect));
                        checkMask("indexCorrect", indexCorrect, eMask[wordLen-1:0]);
                        checkFlag("mistake", pulses != 0, eMistake[0]);
                        checkFlag("red", red, eRed[0]);
                        checkFlag("green", green, eGreen[0]);
                        checkWord("revealedWord", revealedWord,
                                  expectReveal(refWord, eMask[wordLen-1:0]));
                        overSeen = eRed[0] || eGreen[0];
                    end
                    default: begin
                        errors++;
                        $display("unknown command in cases file: %s", line);
                    end
                endcase
            end
        end
        $fclose(fd);
    endtask

    initial begin
        clk        = 1'b0;
        nRst       = 1'b0;
        wordLetter = noKey;
        wordLoad   = 1'b0;
        startGame  = 1'b0;
        gameEnd    = 1'b0;
        guess      = noKey;
        errors     = 0;
        checks     = 0;
        rngState   = 32'd95;
        refWord    = '0;
        countCases();
        repeat (3) @(posedge clk);
        @(negedge clk);
        nRst = 1'b1;
        @(negedge clk);
        checkIdle();
        if (caseCount == 0) begin
            errors++;
            $display("could not read any case from %s", casesFile);
        end else begin
            runCases();
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // watchdog sized from the number of case lines
    initial begin
        wait (caseCount > 0);
        repeat (caseCount * 40 + 100) @(posedge clk);
        $display("timeout after %0d cycles, run did not finish", caseCount * 40 + 100);
        $display("test failed");
        $finish;
    end

endmodule

// ==== project.f ====
hdl/wordGamePkg.sv
hdl/secretWordReg.sv
hdl/guessCapture.sv
hdl/gameLogic.sv
hdl/wordGameTop.sv
sim/wordGameTb.sv

// ==== sim/wordGameCases.txt ====
# cmd: w word(hex) | l letter | s expGameRdy | e | g letter
#      g columns: letter correct incorrect mask mistake red green
w 4150504c45
l 41
l 50
l 50
s 0
l 4c
l 45
s 1
g 50 2 0 0c 0 0 0
g 5a 2 1 0c 1 0 0
g 50 2 2 0c 1 0 0
g 41 3 2 1c 0 0 0
g 4c 4 2 1e 0 0 0
g 45 5 2 1f 0 0 1
g 51 5 2 1f 0 0 1
e
s 0
w 4d414e474f
l 4d
l 41
l 4e
l 47
l 4f
s 1
g 41 1 0 08 0 0 0
g 58 1 1 08 1 0 0
g 59 1 2 08 1 0 0
g 5a 1 3 08 1 0 0
g 41 1 4 08 1 0 0
g 51 1 5 08 1 0 0
g 52 1 6 08 1 1 0
g 4d 1 6 08 0 1 0
e
